//--- hdl/rvPkg.sv
package rvPkg;

  localparam int xlen = 32;
  localparam int regAddrW = 5;
  localparam logic [xlen-1:0] resetPc = 32'h80000000;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    opcLui    = 7'b0110111,
    opcAuipc  = 7'b0010111,
    opcJal    = 7'b1101111,
    opcJalr   = 7'b1100111,
    opcBranch = 7'b1100011,
    opcLoad   = 7'b0000011,
    opcStore  = 7'b0100011,
    opcImm    = 7'b0010011,
    opcOp     = 7'b0110011,
    opcSystem = 7'b1110011
  } opcodeE;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt,
    aluSltu, aluXor, aluSrl, aluSra,
    aluOr, aluAnd, aluPassB
  } aluOpE;

  typedef enum logic {
    aSelReg,
    aSelPc
  } aSelE;

  typedef enum logic [1:0] {
    bSelReg,
    bSelImm,
    bSelCsr
  } bSelE;

  typedef enum logic [1:0] {
    wbMem,
    wbAlu,
    wbPc4,
    wbCsr
  } wbSelE;

  // also carries the store width
  typedef enum logic [2:0] {
    extWord,
    extByteS,
    extHalfS,
    extByteU,
    extHalfU
  } memExtE;

  typedef enum logic [11:0] {
    csrMstatus = 12'h300,
    csrMtvec   = 12'h305,
    csrMepc    = 12'h341,
    csrMcause  = 12'h342
  } csrAddrE;

  localparam logic [xlen-1:0] trapCauseEcall = 32'd11;

endpackage

//--- hdl/ctrlIf.sv
interface ctrlIf import rvPkg::*; ();

  logic [xlen-1:0] imm;
  aluOpE aluOp;
  aSelE aSel;
  bSelE bSel;
  wbSelE wbSel;
  logic regWrite;
  logic memRead;
  logic memWrite;
  memExtE memExt;
  logic branch;
  logic [2:0] branchFunct;
  logic jump;
  logic csrEn;
  logic csrSet;
  logic ecall;
  logic mret;
  logic ebreak;

  modport decoder (
    output imm, aluOp, aSel, bSel, wbSel,
    output regWrite, memRead, memWrite, memExt,
    output branch, branchFunct, jump,
    output csrEn, csrSet, ecall, mret, ebreak
  );

  modport datapath (
    input imm, aluOp, aSel, bSel, wbSel,
    input regWrite, memRead, memWrite, memExt,
    input branch, branchFunct, jump,
    input csrEn, csrSet, ecall, mret, ebreak
  );

endinterface

//--- hdl/decoder.sv
module decoder import rvPkg::*; (
  input logic [31:0] inst,
  ctrlIf.decoder ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic funct7Ok;
  logic [xlen-1:0] immI;
  logic [xlen-1:0] immS;
  logic [xlen-1:0] immB;
  logic [xlen-1:0] immU;
  logic [xlen-1:0] immJ;

  function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: return alt ? aluSub : aluAdd;
      3'b001: return aluSll;
      3'b010: return aluSlt;
      3'b011: return aluSltu;
      3'b100: return aluXor;
      3'b101: return alt ? aluSra : aluSrl;
      3'b110: return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // funct7 = 0x20 only legal for sub and sra
  assign funct7Ok = (funct7 == 7'h00) ||
                    (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl.imm = '0;
    ctrl.aluOp = aluAdd;
    ctrl.aSel = aSelReg;
    ctrl.bSel = bSelReg;
    ctrl.wbSel = wbAlu;
    ctrl.regWrite = 1'b0;
    ctrl.memRead = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.memExt = extWord;
    ctrl.branch = 1'b0;
    ctrl.branchFunct = funct3;
    ctrl.jump = 1'b0;
    ctrl.csrEn = 1'b0;
    ctrl.csrSet = 1'b0;
    ctrl.ecall = 1'b0;
    ctrl.mret = 1'b0;
    ctrl.ebreak = 1'b0;
    case (opcode)
      opcLui: begin
        ctrl.imm = immU;
        ctrl.bSel = bSelImm;
        ctrl.aluOp = aluPassB;
        ctrl.regWrite = 1'b1;
      end
      opcAuipc: begin
        ctrl.imm = immU;
        ctrl.aSel = aSelPc;
        ctrl.bSel = bSelImm;
        ctrl.regWrite = 1'b1;
      end
      opcJal: begin
        ctrl.imm = immJ;
        ctrl.aSel = aSelPc;
        ctrl.bSel = bSelImm;
        ctrl.wbSel = wbPc4;
        ctrl.jump = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opcJalr: begin
        ctrl.imm = immI;
        ctrl.bSel = bSelImm;
        ctrl.wbSel = wbPc4;
        ctrl.jump = (funct3 == 3'b000);
        ctrl.regWrite = (funct3 == 3'b000);
      end
      opcBranch: begin
        ctrl.imm = immB;
        ctrl.aSel = aSelPc;
        ctrl.bSel = bSelImm;
        ctrl.branch = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      opcLoad: begin
        ctrl.imm = immI;
        ctrl.bSel = bSelImm;
        ctrl.wbSel = wbMem;
        ctrl.memRead = 1'b1;
        case (funct3)
          3'b000: ctrl.memExt = extByteS;
          3'b001: ctrl.memExt = extHalfS;
          3'b010: ctrl.memExt = extWord;
          3'b100: ctrl.memExt = extByteU;
          3'b101: ctrl.memExt = extHalfU;
          default: ctrl.memRead = 1'b0;
        endcase
        ctrl.regWrite = ctrl.memRead;
      end
      opcStore: begin
        ctrl.imm = immS;
        ctrl.bSel = bSelImm;
        ctrl.memWrite = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
        ctrl.memExt = (funct3 == 3'b000) ? extByteU :
                      (funct3 == 3'b001) ? extHalfU : extWord;
      end
      opcImm: begin
        ctrl.imm = immI;
        ctrl.bSel = bSelImm;
        ctrl.aluOp = aluFromFunct(funct3, funct3 == 3'b101 && inst[30]);
        // shift immediates carry funct7
        ctrl.regWrite = (funct3 != 3'b001 && funct3 != 3'b101) || funct7Ok;
      end
      opcOp: begin
        ctrl.aluOp = aluFromFunct(funct3, inst[30]);
        ctrl.regWrite = funct7Ok;
      end
      opcSystem: begin
        case (funct3)
          3'b000: begin
            ctrl.ecall = (inst[31:7] == 25'h0);
            ctrl.ebreak = (inst[31:7] == {12'h001, 13'h0});
            ctrl.mret = (inst[31:7] == {12'h302, 13'h0});
          end
          3'b001, 3'b010: begin
            // csrrw / csrrs, old value to rd
            ctrl.csrEn = 1'b1;
            ctrl.csrSet = funct3[1];
            ctrl.bSel = bSelCsr;
            ctrl.aluOp = aluPassB;
            ctrl.wbSel = wbCsr;
            ctrl.regWrite = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/regFile.sv
module regFile import rvPkg::*; (
  input logic clk,
  input logic arstN,
  input logic [regAddrW-1:0] readAddrA,
  input logic [regAddrW-1:0] readAddrB,
  input logic [regAddrW-1:0] writeAddr,
  input logic [xlen-1:0] writeData,
  input logic writeEn,
  output logic [xlen-1:0] readDataA,
  output logic [xlen-1:0] readDataB
);

  // no storage for x0
  logic [xlen-1:0] regs [1:(1 << regAddrW) - 1];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < (1 << regAddrW); i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && writeAddr != '0) begin
      regs[writeAddr] <= writeData;
    end
  end

  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

//--- hdl/csrFile.sv
module csrFile import rvPkg::*; (
  input logic clk,
  input logic arstN,
  ctrlIf.datapath ctrl,
  input logic [11:0] csrAddr,
  input logic [xlen-1:0] writeData,
  input logic [xlen-1:0] pc,
  input logic retireEn,
  output logic [xlen-1:0] readData,
  output logic [xlen-1:0] mtvec,
  output logic [xlen-1:0] mepc
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] newValue;

  always_comb begin
    case (csrAddr)
      csrMstatus: readData = mstatus;
      csrMtvec: readData = mtvec;
      csrMepc: readData = mepc;
      csrMcause: readData = mcause;
      default: readData = '0;
    endcase
  end

  // csrrs sets bits, csrrw replaces
  assign newValue = ctrl.csrSet ? (readData | writeData) : writeData;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mstatus <= '0;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else if (retireEn) begin
      if (ctrl.ecall) begin
        mepc <= pc;
        mcause <= trapCauseEcall;
      end else if (ctrl.csrEn) begin
        case (csrAddr)
          csrMstatus: mstatus <= newValue;
          csrMtvec: mtvec <= newValue;
          csrMepc: mepc <= newValue;
          csrMcause: mcause <= newValue;
          default: ;
        endcase
      end
    end
  end

endmodule

//--- hdl/alu.sv
module alu import rvPkg::*; (
  ctrlIf.datapath ctrl,
  input logic [xlen-1:0] regA,
  input logic [xlen-1:0] regB,
  input logic [xlen-1:0] pc,
  input logic [xlen-1:0] csrValue,
  output logic [xlen-1:0] result,
  output logic branchTaken
);

  logic [xlen-1:0] opA;
  logic [xlen-1:0] opB;
  logic [4:0] shamt;
  logic isEq;
  logic isLt;
  logic isLtu;
  logic cond;

  assign opA = (ctrl.aSel == aSelPc) ? pc : regA;

  always_comb begin
    case (ctrl.bSel)
      bSelImm: opB = ctrl.imm;
      bSelCsr: opB = csrValue;
      default: opB = regB;
    endcase
  end

  assign shamt = opB[4:0];

  always_comb begin
    case (ctrl.aluOp)
      aluSub: result = opA - opB;
      aluSll: result = opA << shamt;
      aluSlt: result = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
      aluSltu: result = {{(xlen-1){1'b0}}, opA < opB};
      aluXor: result = opA ^ opB;
      aluSrl: result = opA >> shamt;
      aluSra: result = $signed(opA) >>> shamt;
      aluOr: result = opA | opB;
      aluAnd: result = opA & opB;
      aluPassB: result = opB;
      default: result = opA + opB;
    endcase
  end

  // branch comparator works on the registers, not the ALU operands
  assign isEq = (regA == regB);
  assign isLt = ($signed(regA) < $signed(regB));
  assign isLtu = (regA < regB);

  always_comb begin
    case (ctrl.branchFunct)
      3'b000: cond = isEq;
      3'b001: cond = !isEq;
      3'b100: cond = isLt;
      3'b101: cond = !isLt;
      3'b110: cond = isLtu;
      3'b111: cond = !isLtu;
      default: cond = 1'b0;
    endcase
  end

  assign branchTaken = ctrl.branch && cond;

endmodule

//--- hdl/loadStore.sv
module loadStore import rvPkg::*; (
  ctrlIf.datapath ctrl,
  input logic [xlen-1:0] addr,
  input logic [xlen-1:0] storeData,
  input logic [xlen-1:0] memRdata,
  output logic [xlen-1:0] memWdata,
  output logic [xlen-1:0] loadData,
  output logic [3:0] memWmask
);

  logic [1:0] offset;
  logic [3:0] laneMask;
  logic [7:0] lane8;
  logic [15:0] lane16;
  logic [xlen-1:0] extended;

  assign offset = addr[1:0];

  // store data replicated over all lanes
  always_comb begin
    case (ctrl.memExt)
      extByteS, extByteU: begin
        memWdata = {4{storeData[7:0]}};
        laneMask = 4'b0001 << offset;
      end
      extHalfS, extHalfU: begin
        memWdata = {2{storeData[15:0]}};
        laneMask = 4'b0011 << {offset[1], 1'b0};
      end
      default: begin
        memWdata = storeData;
        laneMask = 4'b1111;
      end
    endcase
  end

  assign memWmask = ctrl.memWrite ? laneMask : 4'b0000;

  assign lane8 = memRdata[{offset, 3'b000} +: 8];
  assign lane16 = memRdata[{offset[1], 4'b0000} +: 16];

  always_comb begin
    case (ctrl.memExt)
      extByteS: extended = {{24{lane8[7]}}, lane8};
      extHalfS: extended = {{16{lane16[15]}}, lane16};
      extByteU: extended = {24'd0, lane8};
      extHalfU: extended = {16'd0, lane16};
      default: extended = memRdata;
    endcase
  end

  assign loadData = ctrl.memRead ? extended : '0;

endmodule

//--- hdl/rvCore.sv
module rvCore import rvPkg::*; (
  input logic clk,
  input logic arstN,
  input logic [xlen-1:0] imemData,
  input logic [xlen-1:0] dmemRdata,
  output logic [xlen-1:0] imemAddr,
  output logic [xlen-1:0] dmemAddr,
  output logic [xlen-1:0] dmemWdata,
  output logic [3:0] dmemWmask,
  output logic dmemWe,
  output logic halt
);

  ctrlIf ctrl ();

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pcPlus4;
  logic [xlen-1:0] nextPc;
  logic [xlen-1:0] regA;
  logic [xlen-1:0] regB;
  logic [xlen-1:0] aluResult;
  logic [xlen-1:0] csrRead;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] loadData;
  logic [xlen-1:0] wbData;
  logic branchTaken;
  logic retireEn;

  assign retireEn = !halt;
  assign pcPlus4 = pc + 32'd4;

  always_comb begin
    if (ctrl.mret) begin
      nextPc = mepc;
    end else if (ctrl.ecall) begin
      nextPc = mtvec;
    end else if (ctrl.jump || branchTaken) begin
      nextPc = {aluResult[xlen-1:1], 1'b0};
    end else begin
      nextPc = pcPlus4;
    end
  end

  // pc stays on the ebreak once halted
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= resetPc;
      halt <= 1'b0;
    end else if (retireEn) begin
      if (ctrl.ebreak) begin
        halt <= 1'b1;
      end else begin
        pc <= nextPc;
      end
    end
  end

  always_comb begin
    case (ctrl.wbSel)
      wbMem: wbData = loadData;
      wbPc4: wbData = pcPlus4;
      wbCsr: wbData = csrRead;
      default: wbData = aluResult;
    endcase
  end

  decoder decoder_i (
    .inst(imemData),
    .ctrl(ctrl)
  );

  regFile regFile_i (
    .clk(clk),
    .arstN(arstN),
    .readAddrA(imemData[19:15]),
    .readAddrB(imemData[24:20]),
    .writeAddr(imemData[11:7]),
    .writeData(wbData),
    .writeEn(ctrl.regWrite && retireEn),
    .readDataA(regA),
    .readDataB(regB)
  );

  csrFile csrFile_i (
    .clk(clk),
    .arstN(arstN),
    .ctrl(ctrl),
    .csrAddr(imemData[31:20]),
    .writeData(regA),
    .pc(pc),
    .retireEn(retireEn),
    .readData(csrRead),
    .mtvec(mtvec),
    .mepc(mepc)
  );

  alu alu_i (
    .ctrl(ctrl),
    .regA(regA),
    .regB(regB),
    .pc(pc),
    .csrValue(csrRead),
    .result(aluResult),
    .branchTaken(branchTaken)
  );

  loadStore loadStore_i (
    .ctrl(ctrl),
    .addr(aluResult),
    .storeData(regB),
    .memRdata(dmemRdata),
    .memWdata(dmemWdata),
    .loadData(loadData),
    .memWmask(dmemWmask)
  );

  assign imemAddr = pc;
  assign dmemAddr = aluResult;
  // no stores while in reset
  assign dmemWe = ctrl.memWrite && retireEn && arstN;

endmodule

//--- tb/rvCore_assert.sv
module rvCoreAssert import rvPkg::*; (
  input logic clk,
  input logic arstN,
  input logic [xlen-1:0] imemAddr,
  input logic dmemWe,
  input logic halt
);

  int violations = 0;

  noStoreWhenHalted: assert property (@(posedge clk) disable iff (!arstN) halt |-> !dmemWe)
    else begin
      violations++;
      $error("dmemWe high while halted");
    end

  // pc frozen on the ebreak
  pcHeldWhenHalted: assert property (@(posedge clk) disable iff (!arstN)
    halt |=> $stable(imemAddr))
    else begin
      violations++;
      $error("imemAddr moved after halt");
    end

  pcAligned: assert property (@(posedge clk) disable iff (!arstN) imemAddr[1:0] == 2'b00)
    else begin
      violations++;
      $error("imemAddr not word aligned");
    end

endmodule

//--- tb/rvCoreTb.sv
module rvCoreTb import rvPkg::*; ();

  localparam int progMax = 128;
  localparam logic [31:0] nop = 32'h00000013;
  localparam logic [31:0] ebreakInst = 32'h00100073;
  // store word x31 to 0(x31) while in reset or halted
  localparam logic [31:0] strayStore = 32'h01FFA023;

  logic clk;
  logic arstN;
  logic [31:0] imemData;
  logic [31:0] dmemRdata;
  logic [31:0] imemAddr;
  logic [31:0] dmemAddr;
  logic [31:0] dmemWdata;
  logic [3:0] dmemWmask;
  logic dmemWe;
  logic halt;

  logic [31:0] prog [progMax];
  logic [31:0] dmem [64];
  // reference model state
  logic [31:0] mMem [64];
  logic [31:0] mRegs [32];
  logic mLoaded [32];
  logic [31:0] mCsr [4];
  logic [31:0] mPc;
  logic mHalt;
  logic mTrapped;
  logic eWe;
  logic eFromLoad;
  logic [31:0] eAddr;
  logic [31:0] eLane;
  logic [3:0] eMask;
  integer seed;
  int progLen = 0;
  int postHalt;
  int passTotal;
  int failTotal;
  int checks [6];
  int errs [6];
  string testNames [6] = '{"reset", "pc", "store", "load", "trap", "halt"};

  rvCore rvCore_i (
    .clk(clk),
    .arstN(arstN),
    .imemData(imemData),
    .dmemRdata(dmemRdata),
    .imemAddr(imemAddr),
    .dmemAddr(dmemAddr),
    .dmemWdata(dmemWdata),
    .dmemWmask(dmemWmask),
    .dmemWe(dmemWe),
    .halt(halt)
  );

  bind rvCore rvCoreAssert rvCoreAssert_i (
    .clk(clk),
    .arstN(arstN),
    .imemAddr(imemAddr),
    .dmemWe(dmemWe),
    .halt(halt)
  );

  always #50 clk = ~clk;

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opcOp};
  endfunction

  function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opcStore};
  endfunction

  function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
  endfunction

  function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
  endfunction

  function automatic logic [31:0] fetch(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - resetPc;
    if (off[1:0] != 2'b00 || (off >> 2) >= progMax) begin
      return ebreakInst;
    end
    return prog[off >> 2];
  endfunction

  function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3: return (x < y) ? 32'd1 : 32'd0;
      3'd4: return x ^ y;
      3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic int csrSlot(input logic [11:0] addr);
    case (addr)
      csrMstatus: return 0;
      csrMtvec: return 1;
      csrMepc: return 2;
      csrMcause: return 3;
      default: return -1;
    endcase
  endfunction

  task automatic genProgram();
    int idx;
    int skip;
    int size;
    int bodyEnd;
    int hIdx;
    logic [4:0] rd;
    logic [4:0] r1;
    logic [4:0] r2;
    logic [2:0] f3;
    logic [11:0] off;
    logic [2:0] loadF3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    logic [2:0] brF3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    bodyEnd = 65;
    hIdx = bodyEnd + 2;
    for (int i = 0; i < progMax; i++) begin
      prog[i] = ebreakInst;
    end
    // x31 holds the data window base and x30 the handler address
    prog[0] = {20'h00002, 5'd31, opcLui};
    prog[1] = iType(12'h100, 5'd31, 3'd0, 5'd31, opcImm);
    prog[2] = {20'h80000, 5'd30, opcLui};
    prog[3] = iType(12'(hIdx * 4), 5'd30, 3'd0, 5'd30, opcImm);
    prog[4] = iType(csrMtvec, 5'd30, 3'd1, 5'd0, opcSystem);
    idx = 5;
    while (idx < bodyEnd) begin
      rd = 5'(1 + pick(29));
      r1 = 5'(pick(30));
      r2 = 5'(pick(30));
      f3 = 3'(pick(8));
      skip = 2 + int'(pick(3));
      case (pick(8))
        0: begin
          off = 12'(pick(4096));
          if (f3 == 3'd1) begin
            off = {7'h00, off[4:0]};
          end else if (f3 == 3'd5) begin
            off = {off[10] ? 7'h20 : 7'h00, off[4:0]};
          end
          prog[idx] = iType(off, r1, f3, rd, opcImm);
        end
        1: prog[idx] = rType(((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) ? 7'h20 : 7'h00,
                             r2, r1, f3, rd);
        2: prog[idx] = {20'(pick(1 << 20)), rd, opcLui};
        3: begin
          // load followed by a word store of the loaded register
          f3 = loadF3[pick(5)];
          size = 1 << f3[1:0];
          off = 12'(pick(256) & ~(size - 1));
          prog[idx] = iType(off, 5'd31, f3, rd, opcLoad);
          idx++;
          prog[idx] = sType(12'(pick(64) * 4), rd, 5'd31, 3'd2);
        end
        4: begin
          f3 = 3'(pick(3));
          off = 12'(pick(256) & ~((1 << f3) - 1));
          prog[idx] = sType(off, r2, 5'd31, f3);
        end
        5: prog[idx] = (idx + skip <= bodyEnd) ? bType(13'(skip * 4), r2, r1, brF3[pick(6)]) : nop;
        6: prog[idx] = (idx + skip <= bodyEnd) ? jType(21'(skip * 4), rd) : nop;
        default: begin
          // auipc plus jalr skips one slot
          if (idx + 3 <= bodyEnd) begin
            prog[idx] = {20'h0, rd, opcAuipc};
            idx++;
            prog[idx] = iType(12'd12, rd, 3'd0, r2, opcJalr);
          end else begin
            prog[idx] = nop;
          end
        end
      endcase
      idx++;
    end
    prog[bodyEnd] = 32'h00000073;
    prog[bodyEnd + 1] = ebreakInst;
    prog[hIdx] = iType(csrMepc, 5'd0, 3'd2, 5'd29, opcSystem);
    prog[hIdx + 1] = iType(12'd4, 5'd29, 3'd0, 5'd29, opcImm);
    prog[hIdx + 2] = iType(csrMepc, 5'd29, 3'd1, 5'd0, opcSystem);
    prog[hIdx + 3] = 32'h30200073;
    progLen = hIdx + 4;
  endtask

  task automatic stepModel();
    logic [31:0] inst;
    logic [6:0] opc;
    logic [4:0] rd;
    logic [2:0] f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] bImm;
    logic [31:0] next;
    logic [31:0] val;
    logic [31:0] addr;
    logic [31:0] word;
    logic wr;
    logic loaded;
    logic taken;
    int slot;
    inst = fetch(mPc);
    opc = inst[6:0];
    rd = inst[11:7];
    f3 = inst[14:12];
    a = mRegs[inst[19:15]];
    b = mRegs[inst[24:20]];
    iImm = {{20{inst[31]}}, inst[31:20]};
    sImm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    bImm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    next = mPc + 32'd4;
    val = '0;
    wr = 1'b0;
    loaded = 1'b0;
    eWe = 1'b0;
    eFromLoad = 1'b0;
    mTrapped = 1'b0;
    case (opc)
      opcLui: {wr, val} = {1'b1, inst[31:12], 12'h000};
      opcAuipc: {wr, val} = {1'b1, mPc + {inst[31:12], 12'h000}};
      opcJal: begin
        {wr, val} = {1'b1, mPc + 32'd4};
        next = mPc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      opcJalr: begin
        {wr, val} = {1'b1, mPc + 32'd4};
        next = (a + iImm) & ~32'd1;
      end
      opcBranch: begin
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = ($signed(a) < $signed(b));
          3'd5: taken = ($signed(a) >= $signed(b));
          3'd6: taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (taken) begin
          next = mPc + bImm;
        end
      end
      opcLoad: begin
        addr = a + iImm;
        word = mMem[addr[7:2]] >> {addr[1:0], 3'b000};
        case (f3)
          3'd0: val = {{24{word[7]}}, word[7:0]};
          3'd1: val = {{16{word[15]}}, word[15:0]};
          3'd4: val = {24'd0, word[7:0]};
          3'd5: val = {16'd0, word[15:0]};
          default: val = word;
        endcase
        wr = 1'b1;
        loaded = 1'b1;
      end
      opcStore: begin
        eWe = 1'b1;
        eAddr = a + sImm;
        eLane = b << {eAddr[1:0], 3'b000};
        eMask = (f3 == 3'd0) ? 4'b0001 << eAddr[1:0] :
                (f3 == 3'd1) ? 4'b0011 << eAddr[1:0] : 4'b1111;
        eFromLoad = mLoaded[inst[24:20]];
        for (int i = 0; i < 4; i++) begin
          if (eMask[i]) begin
            mMem[eAddr[7:2]][i*8 +: 8] = eLane[i*8 +: 8];
          end
        end
      end
      opcImm: {wr, val} = {1'b1, aluModel(f3, f3 == 3'd5 && inst[30], a, iImm)};
      opcOp: {wr, val} = {1'b1, aluModel(f3, inst[30], a, b)};
      opcSystem: begin
        slot = csrSlot(inst[31:20]);
        if (inst == 32'h00000073) begin
          mCsr[2] = mPc;
          mCsr[3] = trapCauseEcall;
          next = mCsr[1];
          mTrapped = 1'b1;
        end else if (inst == ebreakInst) begin
          mHalt = 1'b1;
          next = mPc;
        end else if (inst == 32'h30200073) begin
          next = mCsr[2];
          mTrapped = 1'b1;
        end else if (f3 == 3'd1 || f3 == 3'd2) begin
          val = (slot < 0) ? 32'd0 : mCsr[slot];
          wr = 1'b1;
          if (slot >= 0) begin
            mCsr[slot] = (f3 == 3'd1) ? a : (val | a);
          end
        end
      end
      default: ;
    endcase
    if (wr && rd != 5'd0) begin
      mRegs[rd] = val;
      mLoaded[rd] = loaded;
    end
    mPc = next;
  endtask

  task automatic compareValue(input int cat, input string name,
                              input logic [31:0] got, input logic [31:0] exp);
    checks[cat]++;
    assert (got === exp) else begin
      errs[cat]++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // a halted core sees a store that it must ignore
  task automatic driveMemories(input logic halted);
    imemData = halted ? strayStore : fetch(imemAddr);
    // let the data address settle on the new instruction
    #1;
    dmemRdata = dmem[dmemAddr[7:2]];
  endtask

  task automatic checkCycle();
    int cat;
    logic [31:0] laneBits;
    cat = mHalt ? 5 : (mTrapped ? 4 : 1);
    compareValue(cat, "imemAddr", imemAddr, mPc);
    compareValue(5, "halt", 32'(halt), 32'(mHalt));
    if (mHalt) begin
      compareValue(5, "dmemWe", 32'(dmemWe), 32'd0);
    end else begin
      stepModel();
      cat = eFromLoad ? 3 : 2;
      compareValue(cat, "dmemWe", 32'(dmemWe), 32'(eWe));
      if (eWe) begin
        laneBits = {{8{eMask[3]}}, {8{eMask[2]}}, {8{eMask[1]}}, {8{eMask[0]}}};
        compareValue(cat, "dmemAddr", dmemAddr, eAddr);
        compareValue(cat, "dmemWmask", 32'(dmemWmask), 32'(eMask));
        compareValue(cat, "dmemWdata", dmemWdata & laneBits, eLane & laneBits);
      end
    end
    // memory takes the write before the next read
    if (dmemWe) begin
      for (int i = 0; i < 4; i++) begin
        if (dmemWmask[i]) begin
          dmem[dmemAddr[7:2]][i*8 +: 8] = dmemWdata[i*8 +: 8];
        end
      end
    end
  endtask

  initial begin
    wait (progLen > 0);
    #((progLen + 20) * 100);
    $display("timeout: core never halted within %0d cycles", progLen + 20);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    clk = 1'b0;
    arstN = 1'b0;
    imemData = strayStore;
    dmemRdata = '0;
    seed = 7540;
    genProgram();
    for (int i = 0; i < 64; i++) begin
      dmem[i] = (32'(i * 4) * 32'h9E3779B1) ^ 32'h5A3C96E1;
      mMem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = '0;
      mLoaded[i] = 1'b0;
    end
    for (int i = 0; i < 4; i++) begin
      mCsr[i] = '0;
    end
    mPc = resetPc;
    mHalt = 1'b0;
    mTrapped = 1'b0;
    repeat (5) begin
      @(negedge clk);
    end
    compareValue(0, "imemAddr", imemAddr, resetPc);
    compareValue(0, "dmemWe", 32'(dmemWe), 32'd0);
    compareValue(0, "halt", 32'(halt), 32'd0);
    $display("%s test finished: %0d checks, %0d errors", testNames[0], checks[0], errs[0]);
    arstN = 1'b1;
    driveMemories(1'b0);
    postHalt = 0;
    while (postHalt < 3) begin
      checkCycle();
      if (mHalt) begin
        postHalt++;
      end
      @(negedge clk);
      driveMemories(mHalt);
    end
    passTotal = 0;
    failTotal = rvCore_i.rvCoreAssert_i.violations;
    for (int i = 1; i < 6; i++) begin
      $display("%s test finished: %0d checks, %0d errors", testNames[i], checks[i], errs[i]);
    end
    for (int i = 0; i < 6; i++) begin
      passTotal += checks[i] - errs[i];
      failTotal += errs[i];
    end
    $display("checks passed %0d, failed %0d (bound assertion failures %0d)",
             passTotal, failTotal, rvCore_i.rvCoreAssert_i.violations);
    if (failTotal == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- rvCore.f
hdl/rvPkg.sv
hdl/ctrlIf.sv
hdl/decoder.sv
hdl/regFile.sv
hdl/csrFile.sv
hdl/alu.sv
hdl/loadStore.sv
hdl/rvCore.sv
tb/rvCore_assert.sv
tb/rvCoreTb.sv
